// File: source/alu_exec.sv
`timescale 1ns/10ps

module alu_exec (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::id_ex_t bundle_i,
    input  logic           fwd1_i,      // take src1 from wb
    input  logic           fwd2_i,      // take src2 from wb
    input  logic           kill_i,
    output rv_pkg::wb_t    wb_o,
    output logic           illegal_o,
    output logic           ebreak_o
);

    logic [rv_pkg::XLEN-1:0]    op_a;
    logic [rv_pkg::XLEN-1:0]    op_b;
    logic [rv_pkg::XLEN-1:0]    result;
    logic [rv_pkg::SHAMT_W-1:0] shamt;
    logic                       issue;   // live slot in execute
    rv_pkg::wb_t                wb_d;

    assign op_a  = fwd1_i ? wb_o.data : bundle_i.src1;   // bypass from previous result
    assign op_b  = fwd2_i ? wb_o.data : bundle_i.src2;
    assign shamt = op_b[rv_pkg::SHAMT_W-1:0];            // rv64 uses 6 bits
    assign issue = bundle_i.ena && !kill_i;

    always_comb begin
        case (bundle_i.alu_op)
            rv_pkg::ADD:    result = op_a + op_b;
            rv_pkg::SUB:    result = op_a - op_b;
            rv_pkg::AND:    result = op_a & op_b;
            rv_pkg::OR:     result = op_a | op_b;
            rv_pkg::XOR:    result = op_a ^ op_b;
            rv_pkg::SLL:    result = op_a << shamt;
            rv_pkg::SRL:    result = op_a >> shamt;
            rv_pkg::SRA:    result = $signed(op_a) >>> shamt;
            rv_pkg::SLT:    result = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU:   result = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
            default:        result = op_b;                // pass_b for lui
        endcase
    end

    always_comb begin
        wb_d.valid = issue && bundle_i.reg_wen;
        wb_d.rd    = bundle_i.rd;
        wb_d.data  = result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_o      <= '0;
            illegal_o <= 1'b0;
            ebreak_o  <= 1'b0;
        end else begin
            wb_o      <= wb_d;
            illegal_o <= issue && bundle_i.illegal;   // one-cycle pulse
            ebreak_o  <= issue && bundle_i.ebreak;
        end
    end

    // decode filters rd zero, so no x0 writeback can come out of here
    assert property (@(posedge clk) disable iff (!rst_n) wb_o.valid |-> (wb_o.rd != '0))
        else $error("alu_exec: writeback to x0");

endmodule

// File: source/id_ex_regs.sv
`timescale 1ns/10ps

module id_ex_regs (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           kill_i,     // drop the slot being captured
    input  rv_pkg::id_ex_t bundle_i,
    output rv_pkg::id_ex_t bundle_o
);

    rv_pkg::id_ex_t bundle_d;

    // killed slot keeps its payload but loses every side effect
    always_comb begin
        bundle_d = bundle_i;
        if (kill_i) begin
            bundle_d.ena     = 1'b0;
            bundle_d.reg_wen = 1'b0;
            bundle_d.ebreak  = 1'b0;
            bundle_d.illegal = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bundle_o    <= '0;
            bundle_o.pc <= rv_pkg::RESET_PC;   // pc field starts at boot vector
        end else begin
            bundle_o    <= bundle_d;           // captured every cycle, no stall
        end
    end

endmodule

// File: source/inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
    input  logic [rv_pkg::ILEN-1:0]       inst_i,
    input  logic [rv_pkg::XLEN-1:0]       pc_i,
    input  logic                          valid_i,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
    output rv_pkg::id_ex_t                bundle_o
);

    rv_pkg::opcode_e               opcode;
    logic [2:0]                    funct3;
    logic [6:0]                    funct7;
    logic [rv_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_pkg::XLEN-1:0]       imm_i;      // sign extended i-type
    logic [rv_pkg::XLEN-1:0]       imm_u;      // sign extended u-type
    rv_pkg::alu_op_e               alu_op;
    logic                          known;      // encoding recognised
    logic                          writes;     // produces a register result
    logic                          is_ebreak;
    logic                          use_rs1;
    logic                          use_rs2;
    logic [rv_pkg::XLEN-1:0]       src1;
    logic [rv_pkg::XLEN-1:0]       src2;

    assign opcode     = rv_pkg::opcode_e'(inst_i[6:0]);
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rd         = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];   // regfile read ports are combinational
    assign rs2_addr_o = inst_i[24:20];
    assign imm_i      = {{(rv_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u      = {{(rv_pkg::XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};

    always_comb begin
        alu_op    = rv_pkg::ADD;
        known     = 1'b0;
        writes    = 1'b0;
        is_ebreak = 1'b0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        src1      = '0;
        src2      = '0;
        case (opcode)
            rv_pkg::OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                writes  = 1'b1;
                src1    = rs1_data_i;
                src2    = rs2_data_i;
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? rv_pkg::SUB : rv_pkg::ADD;
                    3'b001:  alu_op = rv_pkg::SLL;
                    3'b010:  alu_op = rv_pkg::SLT;
                    3'b011:  alu_op = rv_pkg::SLTU;
                    3'b100:  alu_op = rv_pkg::XOR;
                    3'b101:  alu_op = funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                    3'b110:  alu_op = rv_pkg::OR;
                    default: alu_op = rv_pkg::AND;
                endcase
                if (funct7 == 7'b0100000) begin
                    known = (funct3 == 3'b000) || (funct3 == 3'b101);   // sub and sra only
                end else begin
                    known = (funct7 == 7'b0000000);
                end
            end
            rv_pkg::OP_IMM: begin
                use_rs1 = 1'b1;
                writes  = 1'b1;
                known   = 1'b1;
                src1    = rs1_data_i;
                src2    = imm_i;                         // shamt sits in imm[5:0]
                case (funct3)
                    3'b000:  alu_op = rv_pkg::ADD;
                    3'b010:  alu_op = rv_pkg::SLT;
                    3'b011:  alu_op = rv_pkg::SLTU;
                    3'b100:  alu_op = rv_pkg::XOR;
                    3'b110:  alu_op = rv_pkg::OR;
                    3'b111:  alu_op = rv_pkg::AND;
                    3'b001: begin
                        alu_op = rv_pkg::SLL;
                        known  = (inst_i[31:26] == 6'b000000);
                    end
                    default: begin                       // srli / srai
                        alu_op = inst_i[30] ? rv_pkg::SRA : rv_pkg::SRL;
                        known  = (inst_i[31:26] == 6'b000000) || (inst_i[31:26] == 6'b010000);
                    end
                endcase
            end
            rv_pkg::LUI: begin
                alu_op = rv_pkg::PASS_B;                 // src1 stays zero
                writes = 1'b1;
                known  = 1'b1;
                src2   = imm_u;
            end
            rv_pkg::AUIPC: begin
                writes = 1'b1;
                known  = 1'b1;
                src1   = pc_i;
                src2   = imm_u;
            end
            rv_pkg::SYSTEM: begin
                is_ebreak = (inst_i == 32'h0010_0073);   // ecall and csr ops unsupported
                known     = is_ebreak;
            end
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        bundle_o.pc      = pc_i;
        bundle_o.alu_op  = alu_op;
        bundle_o.rs1     = rs1_addr_o;
        bundle_o.rs2     = rs2_addr_o;
        bundle_o.rs1_en  = use_rs1;
        bundle_o.rs2_en  = use_rs2;
        bundle_o.src1    = src1;
        bundle_o.src2    = src2;
        bundle_o.rd      = rd;
        bundle_o.reg_wen = valid_i && known && writes && (rd != '0);   // x0 writes dropped here
        bundle_o.ebreak  = valid_i && is_ebreak;
        bundle_o.illegal = valid_i && !known;
        bundle_o.ena     = valid_i;
    end

    // an unknown encoding must never reach the register file
    assert final (!(bundle_o.reg_wen && bundle_o.illegal))
        else $error("inst_decode: reg_wen set on illegal instruction");

endmodule

// File: source/pipe_ctrl.sv
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::id_ex_t ex_bundle_i,   // slot in execute
    input  rv_pkg::wb_t    wb_i,          // result registered last edge
    input  logic           ebreak_i,      // ebreak pulse out of execute
    output logic           fwd1_o,
    output logic           fwd2_o,
    output logic           kill_id_o,
    output logic           kill_ex_o,
    output logic           halted_o
);

    rv_pkg::run_state_e state_q;
    logic               ebreak_ex;   // ebreak sitting in execute
    logic               halted;

    // operand needs the value still on its way into the regfile
    function automatic logic bypass_hit(
        input logic                          en,
        input logic [rv_pkg::REG_ADDR_W-1:0] addr,
        input rv_pkg::wb_t                   wb
    );
        return en && wb.valid && (wb.rd == addr) && (wb.rd != '0);
    endfunction

    assign ebreak_ex = ex_bundle_i.ena && ex_bundle_i.ebreak;
    assign halted    = (state_q == rv_pkg::HALTED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= rv_pkg::RUN;
        end else if (ebreak_ex) begin
            state_q <= rv_pkg::HALTED;   // sticky until reset
        end
    end

    assign fwd1_o    = bypass_hit(ex_bundle_i.rs1_en, ex_bundle_i.rs1, wb_i);
    assign fwd2_o    = bypass_hit(ex_bundle_i.rs2_en, ex_bundle_i.rs2, wb_i);
    assign kill_id_o = halted || ebreak_ex;   // decode slot is younger than the ebreak
    assign kill_ex_o = halted;                // execute slot is younger once halted
    assign halted_o  = halted;

    assert property (@(posedge clk) disable iff (!rst_n) halted_o |=> halted_o)
        else $error("pipe_ctrl: halted_o dropped without reset");

    // the slot right behind a retiring ebreak never writes back
    assert property (@(posedge clk) disable iff (!rst_n) ebreak_i |=> !wb_i.valid)
        else $error("pipe_ctrl: writeback after ebreak");

endmodule

// File: source/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    input  rv_pkg::wb_t                   wb_i
);

    logic [rv_pkg::XLEN-1:0] regs_q [rv_pkg::NUM_REGS];
    logic                    wr_en;

    assign wr_en = wb_i.valid && (wb_i.rd != '0);   // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so decode sees a result one slot back
    assign rs1_data_o = (rs1_addr_i == '0)                   ? '0        :   // x0 reads zero
                        (wr_en && (wb_i.rd == rs1_addr_i)) ? wb_i.data :
                                                              regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                   ? '0        :
                        (wr_en && (wb_i.rd == rs2_addr_i)) ? wb_i.data :
                                                              regs_q[rs2_addr_i];

endmodule

// File: source/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [rv_pkg::ILEN-1:0] inst_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    input  logic                    inst_valid_i,   // one strobe per instruction
    output rv_pkg::wb_t             wb_o,
    output logic                    illegal_o,
    output logic                    halted_o
);

    logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_pkg::XLEN-1:0]       rs1_data;
    logic [rv_pkg::XLEN-1:0]       rs2_data;
    rv_pkg::id_ex_t                id_bundle;   // decode output
    rv_pkg::id_ex_t                ex_bundle;   // registered for execute
    logic                          fwd1;
    logic                          fwd2;
    logic                          kill_id;
    logic                          kill_ex;
    logic                          ebreak_pulse;

    inst_decode u_decode (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .valid_i    (inst_valid_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .bundle_o   (id_bundle)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_o)          // writeback stage feeds the regfile
    );

    id_ex_regs u_id_ex (
        .clk      (clk),
        .rst_n    (rst_n),
        .kill_i   (kill_id),
        .bundle_i (id_bundle),
        .bundle_o (ex_bundle)
    );

    alu_exec u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .bundle_i  (ex_bundle),
        .fwd1_i    (fwd1),
        .fwd2_i    (fwd2),
        .kill_i    (kill_ex),
        .wb_o      (wb_o),
        .illegal_o (illegal_o),
        .ebreak_o  (ebreak_pulse)
    );

    pipe_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_bundle_i (ex_bundle),
        .wb_i        (wb_o),
        .ebreak_i    (ebreak_pulse),
        .fwd1_o      (fwd1),
        .fwd2_o      (fwd2),
        .kill_id_o   (kill_id),
        .kill_ex_o   (kill_ex),
        .halted_o    (halted_o)
    );

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 64;   // data and pc width
    localparam int ILEN       = 32;   // instruction width
    localparam int REG_ADDR_W = 5;    // register index width
    localparam int NUM_REGS   = 32;   // x0..x31
    localparam int SHAMT_W    = 6;    // rv64 shift amount bits
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // major opcodes handled by this slice
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // reg-reg alu
        OP_IMM = 7'b0010011,   // reg-imm alu
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        SYSTEM = 7'b1110011    // only ebreak accepted
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,      // arithmetic right shift
        SLT,      // signed compare
        SLTU,     // unsigned compare
        PASS_B    // lui result
    } alu_op_e;

    typedef enum logic {
        RUN,
        HALTED
    } run_state_e;

    // decoded slot crossing id/ex
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs1_en;    // src1 came from a register
        logic                  rs2_en;    // src2 came from a register
        logic [XLEN-1:0]       src1;
        logic [XLEN-1:0]       src2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_wen;
        logic                  ebreak;
        logic                  illegal;
        logic                  ena;       // slot holds a real instruction
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// File: src.f
source/rv_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/id_ex_regs.sv
source/alu_exec.sv
source/pipe_ctrl.sv
source/rv_core_top.sv
tests/tb_rv_core.sv

// File: tests/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

    localparam int RST_CYCLES = 10;
    localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

    typedef struct packed {
        logic        vld;        // slot carries an instruction
        logic [31:0] inst;
        logic [63:0] pc;
        rv_pkg::wb_t exp_wb;
        logic        exp_ill;
        logic        exp_halt;   // level expected once this slot retires
    } vec_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic [31:0]             inst_i;
    logic [rv_pkg::XLEN-1:0] pc_i;
    logic                    inst_valid_i;
    rv_pkg::wb_t             wb_o;
    logic                    illegal_o;
    logic                    halted_o;

    vec_t                    tbl [$];
    logic [63:0]             model_regs [32];   // architectural reference
    logic                    halted_m;
    logic [63:0]             next_pc;
    int                      seed = 32'hbb6a328f;
    int                      cycle_cnt = 0;
    int                      max_cycles = 0;

    rv_core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .inst_valid_i (inst_valid_i),
        .wb_o         (wb_o),
        .illegal_o    (illegal_o),
        .halted_o     (halted_o)
    );

    always #20 clk = ~clk;   // 40 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > max_cycles) begin
            abort_run("the run timed out before the instruction table was finished");
        end
    end

    task automatic check_wb(input rv_pkg::wb_t got, input rv_pkg::wb_t exp);
        if (got.valid !== exp.valid ||
            (exp.valid && (got.rd !== exp.rd || got.data !== exp.data))) begin
            abort_run($sformatf("MISMATCH wb_o exp %h got %h", exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s exp %h got %h", name, exp, got));
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, rv_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input rv_pkg::opcode_e opc);
        return {imm, rd, opc};
    endfunction

    // isa model, retires one instruction and records what the ports must show
    task automatic add_vec(input logic [31:0] inst);
        vec_t        v;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic        legal;
        logic        writes;
        a      = model_regs[inst[19:15]];
        b      = model_regs[inst[24:20]];
        legal  = 1'b1;
        writes = 1'b1;
        case (inst[6:0])
            7'h33: legal = (inst[31:25] == 7'h00) ||
                           (inst[31:25] == 7'h20 && (inst[14:12] == 3'd0 || inst[14:12] == 3'd5));
            7'h13: begin
                b = {{52{inst[31]}}, inst[31:20]};
                if (inst[14:12] == 3'd1) begin
                    legal = (inst[31:26] == 6'h00);
                end else if (inst[14:12] == 3'd5) begin
                    legal = (inst[31:26] == 6'h00) || (inst[31:26] == 6'h10);
                end
            end
            7'h37, 7'h17: legal = 1'b1;
            default: begin
                writes = 1'b0;                   // only ebreak is accepted here
                legal  = (inst == EBREAK_INST);
            end
        endcase
        case (inst[14:12])
            3'd0: r = (inst[6:0] == 7'h33 && inst[30]) ? a - b : a + b;
            3'd1: r = a << b[5:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3: r = (a < b) ? 64'd1 : 64'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (inst[30]) begin
                    r = $signed(a) >>> b[5:0];   // sign fill
                end else begin
                    r = a >> b[5:0];
                end
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        if (inst[6:0] == 7'h37) begin
            r = {{32{inst[31]}}, inst[31:12], 12'h000};
        end
        if (inst[6:0] == 7'h17) begin
            r = next_pc + {{32{inst[31]}}, inst[31:12], 12'h000};
        end
        if (inst == EBREAK_INST) begin
            halted_m = 1'b1;
        end
        v.vld          = 1'b1;
        v.inst         = inst;
        v.pc           = next_pc;
        v.exp_wb.valid = legal && writes && (inst[11:7] != 5'd0);
        v.exp_wb.rd    = inst[11:7];
        v.exp_wb.data  = r;
        v.exp_ill      = !legal;
        v.exp_halt     = halted_m;
        if (v.exp_wb.valid) begin
            model_regs[inst[11:7]] = r;
        end
        tbl.push_back(v);
        next_pc += 64'd4;
    endtask

    task automatic add_idle();
        vec_t v;
        v          = '0;
        v.exp_halt = halted_m;   // halt level must hold through bubbles
        tbl.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_vec(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1));              // x0 + x0
        for (int r = 1; r <= 6; r++) begin
            rnd = $random(seed);
            if (r == 1) begin
                rnd[31] = 1'b1;                                     // negative source
            end
            if (r == 2) begin
                rnd[31] = 1'b0;
            end
            add_vec(enc_u(rnd[31:12], 5'(r), rv_pkg::LUI));
            add_vec(enc_i(rnd[11:0], 5'(r), 3'd0, 5'(r)));          // back-to-back on rd
        end
        add_vec(enc_i(12'hffb, 5'd0, 3'd0, 5'd9));                  // x9 = -5
        for (int f = 0; f < 8; f++) begin
            add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(10 + f)));
        end
        add_vec(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd18));             // sub
        add_vec(enc_r(7'h20, 5'd3, 5'd9, 3'd5, 5'd19));             // sra of negative
        add_vec(enc_r(7'h00, 5'd2, 5'd9, 3'd3, 5'd24));             // sltu negative
        add_vec(enc_r(7'h00, 5'd2, 5'd9, 3'd2, 5'd25));             // slt negative
        for (int f = 0; f < 8; f++) begin
            rnd = $random(seed);
            if (f == 1 || f == 5) begin
                rnd[11:6] = 6'h00;                                  // slli / srli
            end
            add_vec(enc_i(rnd[11:0], 5'd1, 3'(f), 5'(10 + f)));
        end
        rnd = $random(seed);
        add_vec(enc_i({6'h10, rnd[5:0]}, 5'd1, 3'd5, 5'd26));       // srai
        add_vec(enc_i(12'h005, 5'd9, 3'd3, 5'd27));                 // sltiu negative
        add_vec(enc_u(rnd[31:12], 5'd28, rv_pkg::LUI));
        add_vec(enc_u(rnd[19:0], 5'd29, rv_pkg::AUIPC));
        add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd20));
        add_vec(enc_r(7'h00, 5'd20, 5'd20, 3'd0, 5'd21));           // bypass both operands
        add_vec(enc_r(7'h20, 5'd21, 5'd20, 3'd0, 5'd22));           // write-through and bypass
        add_vec(enc_i(12'h005, 5'd1, 3'd0, 5'd0));                  // write to x0
        add_vec(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd23));             // x0 still zero
        add_vec(32'h0000_0000);                                     // unknown opcode
        add_vec(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));              // mul not supported
        add_vec(32'h0000_0073);                                     // ecall not supported
        add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd30));
        add_vec(EBREAK_INST);
        for (int i = 0; i < 3; i++) begin
            add_idle();
        end
    endtask

    initial begin
        rv_pkg::wb_t idle_wb;
        idle_wb      = '0;
        rst_n        = 1'b0;
        inst_i       = '0;
        pc_i         = rv_pkg::RESET_PC;
        inst_valid_i = 1'b0;
        halted_m     = 1'b0;
        next_pc      = rv_pkg::RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        max_cycles = tbl.size() + 2 + RST_CYCLES + 20;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_wb(wb_o, idle_wb);
        check_flag("illegal_o", illegal_o, 1'b0);
        check_flag("halted_o", halted_o, 1'b0);
        for (int j = 0; j < tbl.size() + 2; j++) begin
            if (j >= 2) begin                                       // result of slot j-2
                check_wb(wb_o, tbl[j-2].exp_wb);
                check_flag("illegal_o", illegal_o, tbl[j-2].exp_ill);
                check_flag("halted_o", halted_o, tbl[j-2].exp_halt);
            end
            if (j < tbl.size()) begin
                inst_valid_i = tbl[j].vld;
                inst_i       = tbl[j].inst;
                pc_i         = tbl[j].pc;
            end else begin
                inst_valid_i = 1'b0;
            end
            @(negedge clk);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
